// ==== Makefile ====
# Verilator lint, simulation and cleanup for the SpaceWire transmitter
TOP = spw_tx_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f verilog.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP) -Mdir obj_dir -o sim_$(TOP)
	./obj_dir/sim_$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@grep -qF "*** TEST PASSED ***" sim.log && ! grep -qF "*** TEST FAILED ***" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== dv/spw_tx_decode.svh ====
// Data/strobe bit recovery and character parsing tasks for the transmitter testbench
`ifndef SPW_TX_DECODE_SVH
`define SPW_TX_DECODE_SVH

// Decoded character kinds, same codes as the expected lines of the golden file
localparam logic [3:0] TOK_NULL = 4'h8;
localparam logic [3:0] TOK_FCT  = 4'h9;
localparam logic [3:0] TOK_EOP  = 4'ha;
localparam logic [3:0] TOK_EEP  = 4'hb;
localparam logic [3:0] TOK_DATA = 4'hc;
localparam logic [3:0] TOK_TIME = 4'hd;

// Line levels at the last sample
logic       prev_d;
logic       prev_s;
// Data bits of the previous character, zero after a control character
logic [7:0] hist;
// First bit, caught while waiting for the lines to start
logic       first_bit;
logic       first_pending;

// Lines sit at zero until the first bit moves one of them
task automatic wait_line_start();
	int tmo;
	tmo           = 0;
	prev_d        = 1'b0;
	prev_s        = 1'b0;
	hist          = '0;
	first_pending = 1'b0;
	while (!first_pending)
	begin
		@(negedge pclk_tx);
		if (d_o && s_o)
			fail_run("d_o and s_o both rose on the first bit");
		if (d_o || s_o)
		begin
			first_bit     = d_o;
			first_pending = 1'b1;
			prev_d        = d_o;
			prev_s        = s_o;
		end
		tmo++;
		if (!first_pending && tmo > WAIT_TMO)
			fail_run("lines never started toggling after send_null_i");
	end
endtask

// One bit per clock, taken as the level of d_o
task automatic read_bit(output logic b);
	logic dch;
	logic sch;
	if (first_pending)
	begin
		b             = first_bit;
		first_pending = 1'b0;
	end
	else
	begin
		@(negedge pclk_tx);
		dch = d_o ^ prev_d;
		sch = s_o ^ prev_s;
		if (dch == sch)
			fail_run("d_o and s_o did not change by exactly one line in a clock");
		prev_d = d_o;
		prev_s = s_o;
		b      = d_o;
	end
endtask

// Parity, flag, then two code bits or eight data bits, lsb first
task automatic read_char(output logic flag, output logic [7:0] bits);
	logic p;
	logic b;
	logic want_p;
	int   n;
	read_bit(p);
	read_bit(flag);
	// Odd over previous data bits, own parity bit and own flag
	want_p = ~(^hist ^ flag);
	n      = flag ? 2 : 8;
	bits   = '0;
	for (int i = 0; i < n; i++)
	begin
		read_bit(b);
		bits = {b, bits[7:1]};
	end
	// Two code bits end up at the top
	if (flag)
		bits = {6'b0, bits[7:6]};
	compare_value("parity bit", 32'(p), 32'(want_p));
	hist = flag ? 8'h00 : bits;
endtask

// Escape pairs up with the following character
task automatic read_token(output logic [3:0] kind, output logic [7:0] val);
	logic       flag;
	logic [7:0] bits;
	kind = TOK_NULL;
	val  = '0;
	read_char(flag, bits);
	if (!flag)
	begin
		kind = TOK_DATA;
		val  = bits;
	end
	else if (bits[1:0] == 2'b00)
		kind = TOK_FCT;
	else if (bits[1:0] == 2'b01)
		kind = TOK_EOP;
	else if (bits[1:0] == 2'b10)
		kind = TOK_EEP;
	else
	begin
		read_char(flag, bits);
		// ESC+FCT is NULL, ESC+data is a time code
		if (!flag)
		begin
			kind = TOK_TIME;
			val  = bits;
		end
		else if (bits[1:0] != 2'b00)
			fail_run("escape followed by a control code other than FCT");
	end
endtask

`endif

// ==== dv/spw_tx_tb.sv ====
// Testbench for the SpaceWire transmitter, stimulus and expected characters from a golden file
`timescale 1ns/1ps

module spw_tx_tb;

	// Golden file ops for stimulus lines
	localparam logic [3:0] OP_END  = 4'h0;
	localparam logic [3:0] OP_TC   = 4'h1;
	localparam logic [3:0] OP_FCT  = 4'h2;
	localparam logic [3:0] OP_DATA = 4'h3;
	// Longest any wait may take, in clocks
	localparam int         WAIT_TMO = 100;

	logic        pclk_tx;
	logic        enable_tx;
	logic        send_null_i;
	logic        tc_valid_i;
	logic [7:0]  tc_i;
	logic        tc_ready_o;
	logic        fct_valid_i;
	logic        fct_ready_o;
	logic        data_valid_i;
	logic [8:0]  data_i;
	logic        data_ready_o;
	logic        d_o;
	logic        s_o;

	// Three words per line for op, value and hold
	logic [11:0] gold_mem [0:255];
	logic [31:0] rnd_state;
	// Every expected character has been decoded
	logic        exp_done;

	spw_tx dut_i (.*);

	initial
	begin
		pclk_tx = 1'b0;
		forever
			#10 pclk_tx = ~pclk_tx;
	end

	// ----------------------------------------------------------
	// Checks and helpers
	// ----------------------------------------------------------

	task automatic fail_run(input string what);
		$display("%s", what);
		$display("*** TEST FAILED ***");
		$fatal(1);
	endtask

	task automatic compare_value(input string name, input logic [31:0] got,
		input logic [31:0] want);
		if (got !== want)
			fail_run($sformatf("mismatch %s got %h expected %h", name, got, want));
	endtask

	function automatic logic [31:0] next_rand(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// Any source still offering when op is OP_END
	function automatic logic source_busy(input logic [3:0] op);
		case (op)
			OP_TC:   return tc_valid_i;
			OP_FCT:  return fct_valid_i;
			OP_DATA: return data_valid_i;
			default: return tc_valid_i | fct_valid_i | data_valid_i;
		endcase
	endfunction

	`include "spw_tx_decode.svh"

	// Sample handshakes mid cycle, drop accepted valids after the edge
	task automatic step_cycle();
		logic tc_acc;
		logic fct_acc;
		logic data_acc;
		@(negedge pclk_tx);
		if ((tc_ready_o && !tc_valid_i) || (fct_ready_o && !fct_valid_i) ||
			(data_ready_o && !data_valid_i))
			fail_run("a ready rose with no item offered on its source");
		tc_acc   = tc_valid_i && tc_ready_o;
		fct_acc  = fct_valid_i && fct_ready_o;
		data_acc = data_valid_i && data_ready_o;
		@(posedge pclk_tx);
		#2;
		if (tc_acc)
			tc_valid_i = 1'b0;
		if (fct_acc)
			fct_valid_i = 1'b0;
		if (data_acc)
			data_valid_i = 1'b0;
	endtask

	task automatic wait_accepted(input logic [3:0] op);
		int tmo;
		tmo = 0;
		while (source_busy(op))
		begin
			step_cycle();
			tmo++;
			if (tmo > WAIT_TMO)
				fail_run("an offered item was never accepted");
		end
	endtask

	task automatic offer_item(input logic [3:0] op, input logic [8:0] val);
		wait_accepted(op);
		case (op)
			OP_TC:
			begin
				tc_i       = val[7:0];
				tc_valid_i = 1'b1;
			end
			OP_FCT:
			begin
				fct_valid_i = 1'b1;
			end
			OP_DATA:
			begin
				data_i       = val;
				data_valid_i = 1'b1;
			end
			default:
				fail_run("unknown op in the golden file");
		endcase
	endtask

	// Lines stay at zero while step_cycle watches the readys
	task automatic check_quiet_lines(input int n);
		repeat (n)
		begin
			step_cycle();
			compare_value("d_o", 32'(d_o), 32'd0);
			compare_value("s_o", 32'(s_o), 32'd0);
		end
	endtask

	// Next expected line at or after pos
	function automatic logic [7:0] next_expected(input logic [7:0] from);
		logic [7:0] p;
		p = from;
		while (gold_mem[p][3:0] != OP_END && gold_mem[p][3:0] < TOK_NULL)
			p = p + 8'd3;
		return p;
	endfunction

	// ----------------------------------------------------------
	// Decoded stream against the expected lines
	// ----------------------------------------------------------

	initial
	begin : decode
		logic [3:0] kind;
		logic [7:0] val;
		logic [7:0] pos;
		exp_done = 1'b0;
		wait_line_start();
		pos = next_expected(8'd0);
		read_token(kind, val);
		compare_value("first character kind", 32'(kind), 32'(TOK_NULL));
		forever
		begin
			if (gold_mem[pos][3:0] == OP_END)
				exp_done = 1'b1;
			read_token(kind, val);
			// NULLs fill idle time and may appear anywhere
			if (kind != TOK_NULL)
			begin
				if (exp_done)
					fail_run("a character was decoded after the expected list ran out");
				compare_value("decoded kind", 32'(kind), 32'(gold_mem[pos][3:0]));
				compare_value("decoded value", 32'(val), 32'(gold_mem[pos + 8'd1][7:0]));
				pos = next_expected(pos + 8'd3);
			end
		end
	end

	// ----------------------------------------------------------
	// Stimulus
	// ----------------------------------------------------------

	initial
	begin : stimulus
		logic [7:0] idx;
		logic [3:0] op;
		logic [7:0] hold;
		int         tmo;
		enable_tx    = 1'b0;
		send_null_i  = 1'b0;
		tc_valid_i   = 1'b0;
		tc_i         = '0;
		fct_valid_i  = 1'b0;
		data_valid_i = 1'b0;
		data_i       = '0;
		rnd_state    = 32'h85a6;
		$readmemh("dv/tx_golden.txt", gold_mem);
		check_quiet_lines(4);
		enable_tx = 1'b1;
		// Out of reset but not started yet
		check_quiet_lines(3);
		send_null_i = 1'b1;
		// First NULL gets the holding register before any source
		repeat (12)
			step_cycle();
		idx = 8'd0;
		op  = gold_mem[idx][3:0];
		while (op != OP_END)
		begin
			if (op < TOK_NULL)
			begin
				offer_item(op, gold_mem[idx + 8'd1][8:0]);
				hold = gold_mem[idx + 8'd2][7:0];
				// Hold of zero joins the next line in the same cycle
				if (hold != 8'd0)
				begin
					wait_accepted(OP_END);
					rnd_state = next_rand(rnd_state);
					repeat (int'(hold) + int'(rnd_state[17:16]))
						step_cycle();
				end
			end
			idx = idx + 8'd3;
			op  = gold_mem[idx][3:0];
		end
		wait_accepted(OP_END);
		tmo = 0;
		while (!exp_done)
		begin
			step_cycle();
			tmo++;
			if (tmo > WAIT_TMO)
				fail_run("expected characters never appeared on the lines");
		end
		// Idle tail where the decoder takes only NULLs
		repeat (40)
			step_cycle();
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

// ==== dv/tx_golden.txt ====
// Columns: op, value (hex), hold clocks after the group is accepted (0 joins the next line)
// Ops: 1 time code, 2 FCT, 3 data word; expected 9 FCT, A EOP, B EEP, C data, D time; 0 ends
3 041 01
C 041 00
3 0a5 01
C 0a5 00
3 100 02
A 000 00
1 05a 00
3 033 03
D 05a 00
C 033 00
2 000 02
9 000 00
2 000 1e
9 000 00
3 077 00
2 000 00
1 0c3 04
D 0c3 00
9 000 00
C 077 00
3 0ff 00
3 101 02
C 0ff 00
B 000 00
0 000 00

// ==== rtl/spw_char_if.sv ====
// Character handshake interface between selection and serialization
`timescale 1ns/1ps

interface spw_char_if;
	import spw_tx_pkg::*;

	// Character waiting in the holding register
	logic              valid;
	// Serializer can take a character this cycle
	logic              ready;
	// What the body means
	logic [KIND_W-1:0] kind;
	// Byte or control field
	char_body_u        body;

	// Selector side
	modport src (
		output valid,
		output kind,
		output body,
		input  ready
	);

	// Serializer side
	modport dst (
		input  valid,
		input  kind,
		input  body,
		output ready
	);

endinterface

// ==== rtl/spw_char_select.sv ====
// Start latch, fixed priority character choice and holding register
`timescale 1ns/1ps

module spw_char_select (
	input  logic                          pclk_tx,
	input  logic                          enable_tx,
	input  logic                          send_null_i,
	input  logic                          tc_valid_i,
	input  logic [spw_tx_pkg::BYTE_W-1:0] tc_i,
	input  logic                          fct_valid_i,
	input  logic                          data_valid_i,
	input  logic [spw_tx_pkg::BYTE_W:0]   data_i,
	output logic                          tc_ready_o,
	output logic                          fct_ready_o,
	output logic                          data_ready_o,
	spw_char_if.src                       out_if
);
	import spw_tx_pkg::*;

	// Link may send once send_null_i was seen
	logic              started_q;
	logic              hold_valid_q;
	logic [KIND_W-1:0] hold_kind_q;
	char_body_u        hold_body_q;
	// Holding register takes a new character
	logic              load;
	logic [KIND_W-1:0] next_kind;
	char_body_u        next_body;

	// Refill when empty or when drained this cycle
	assign load = started_q && (!hold_valid_q || out_if.ready);

	// ----------------------------------------------------------
	// Priority choice
	// ----------------------------------------------------------

	always_comb
	begin
		// NULL when nothing waits
		next_kind           = KIND_NULL;
		next_body           = '0;
		next_body.ctrl.code = CODE_ESC;
		tc_ready_o          = 1'b0;
		fct_ready_o         = 1'b0;
		data_ready_o        = 1'b0;
		if (tc_valid_i)
		begin
			next_kind      = KIND_TIME;
			next_body.data = tc_i;
			tc_ready_o     = load;
		end
		else if (fct_valid_i)
		begin
			next_kind           = KIND_FCT;
			next_body.ctrl.code = CODE_FCT;
			fct_ready_o         = load;
		end
		else if (data_valid_i)
		begin
			data_ready_o = load;
			if (data_i[BYTE_W])
			begin
				// Flagged word marks the packet end
				next_kind           = data_i[0] ? KIND_EEP : KIND_EOP;
				next_body.ctrl.code = data_i[0] ? CODE_EEP : CODE_EOP;
			end
			else
			begin
				next_kind      = KIND_DATA;
				next_body.data = data_i[BYTE_W-1:0];
			end
		end
	end

	// ----------------------------------------------------------
	// Start latch and holding register
	// ----------------------------------------------------------

	always_ff @(posedge pclk_tx or negedge enable_tx)
	begin
		if (!enable_tx)
		begin
			started_q    <= 1'b0;
			hold_valid_q <= 1'b0;
		end
		else
		begin
			started_q <= started_q | send_null_i;
			// Stays full from here on since NULL always fills it
			if (load)
				hold_valid_q <= 1'b1;
		end
	end

	// Payload of the held character
	always_ff @(posedge pclk_tx)
	begin
		if (load)
		begin
			hold_kind_q <= next_kind;
			hold_body_q <= next_body;
		end
	end

	assign out_if.valid = hold_valid_q;
	assign out_if.kind  = hold_kind_q;
	assign out_if.body  = hold_body_q;

	// One source accepted per cycle at most
	a_one_ready: assert property (@(posedge pclk_tx) disable iff (!enable_tx)
		$onehot0({tc_ready_o, fct_ready_o, data_ready_o}));

endmodule

// ==== rtl/spw_char_serialize.sv ====
// Character shift register with parity insertion and data bit history
`timescale 1ns/1ps

module spw_char_serialize (
	input  logic    pclk_tx,
	input  logic    enable_tx,
	spw_char_if.dst in_if,
	output logic    bit_o,
	output logic    bit_valid_o
);
	import spw_tx_pkg::*;

	// Character on the way out
	logic                busy_q;
	// Index of the bit now on bit_o
	logic [CNT_W-1:0]    cnt_q;
	logic [CNT_W-1:0]    len_q;
	logic [LEN_TIME-1:0] shift_q;
	// Data bits of the previous character
	logic [BYTE_W-1:0]   hist_q;
	logic                last_bit;
	logic                take;
	// XOR of the history bits
	logic                hist_par;
	logic                par_ctrl;
	logic                par_data;
	logic [LEN_TIME-1:0] load_vec;
	logic [CNT_W-1:0]    load_len;
	logic [BYTE_W-1:0]   load_hist;

	assign last_bit = busy_q && (cnt_q == len_q - 1'b1);
	// Next character lines up right behind the last bit
	assign in_if.ready = !busy_q || last_bit;
	assign take        = in_if.valid && in_if.ready;

	// Odd parity over history and own flag
	assign hist_par = ^hist_q;
	assign par_ctrl = ~(hist_par ^ 1'b1);
	assign par_data = ~(hist_par ^ 1'b0);

	// ----------------------------------------------------------
	// Character build
	// ----------------------------------------------------------

	// Bit 0 leaves first
	always_comb
	begin
		load_vec  = '0;
		load_len  = LEN_CTRL;
		load_hist = '0;
		case (in_if.kind)
			KIND_DATA:
			begin
				load_vec[9:0] = {in_if.body.data, 1'b0, par_data};
				load_len      = LEN_DATA;
				load_hist     = in_if.body.data;
			end
			KIND_NULL:
			begin
				// Inner FCT parity covers no data bits and its flag
				load_vec[7:0] = {CODE_FCT, 1'b1, 1'b0, CODE_ESC, 1'b1, par_ctrl};
				load_len      = LEN_NULL;
			end
			KIND_TIME:
			begin
				// Inner data character after ESC has odd parity 1
				load_vec  = {in_if.body.data, 1'b0, 1'b1, CODE_ESC, 1'b1, par_ctrl};
				load_len  = LEN_TIME;
				load_hist = in_if.body.data;
			end
			default:
			begin
				// FCT, EOP and EEP
				load_vec[3:0] = {in_if.body.ctrl.code, 1'b1, par_ctrl};
			end
		endcase
	end

	// ----------------------------------------------------------
	// Bit counter and history
	// ----------------------------------------------------------

	always_ff @(posedge pclk_tx or negedge enable_tx)
	begin
		if (!enable_tx)
		begin
			busy_q <= 1'b0;
			cnt_q  <= '0;
			hist_q <= '0;
		end
		else if (take)
		begin
			busy_q <= 1'b1;
			cnt_q  <= '0;
			hist_q <= load_hist;
		end
		else if (busy_q)
		begin
			if (last_bit)
			begin
				busy_q <= 1'b0;
				cnt_q  <= '0;
			end
			else
				cnt_q <= cnt_q + 1'b1;
		end
	end

	// Shift register and its length
	always_ff @(posedge pclk_tx)
	begin
		if (take)
		begin
			shift_q <= load_vec;
			len_q   <= load_len;
		end
		else if (busy_q)
			shift_q <= shift_q >> 1;
	end

	assign bit_o       = shift_q[0];
	assign bit_valid_o = busy_q;

	// Counter stays inside the loaded character
	a_cnt_in_len: assert property (@(posedge pclk_tx) disable iff (!enable_tx)
		busy_q |-> (cnt_q < len_q));

endmodule

// ==== rtl/spw_ds_encode.sv ====
// Data/strobe line coding of the serial bit stream
`timescale 1ns/1ps

module spw_ds_encode (
	input  logic pclk_tx,
	input  logic enable_tx,
	input  logic bit_i,
	input  logic bit_valid_i,
	output logic d_o,
	output logic s_o
);

	// ----------------------------------------------------------
	// Line registers
	// ----------------------------------------------------------

	// D carries the bit itself
	// S toggles when D would not change
	always_ff @(posedge pclk_tx or negedge enable_tx)
	begin
		if (!enable_tx)
		begin
			d_o <= 1'b0;
			s_o <= 1'b0;
		end
		else if (bit_valid_i)
		begin
			d_o <= bit_i;
			// Repeated bit moves the strobe
			if (bit_i == d_o)
				s_o <= ~s_o;
		end
	end

	// Lines hold while no bit is offered

	// Exactly one line moves for each bit sent
	a_one_edge: assert property (@(posedge pclk_tx) disable iff (!enable_tx)
		bit_valid_i |=> ($changed(d_o) ^ $changed(s_o)));

endmodule

// ==== rtl/spw_tx.sv ====
// SpaceWire transmitter top level with selection, serialization and line coding
`timescale 1ns/1ps

module spw_tx (
	input  logic                          pclk_tx,
	input  logic                          enable_tx,
	input  logic                          send_null_i,
	// Time code source
	input  logic                          tc_valid_i,
	input  logic [spw_tx_pkg::BYTE_W-1:0] tc_i,
	output logic                          tc_ready_o,
	// FCT request
	input  logic                          fct_valid_i,
	output logic                          fct_ready_o,
	// Data, EOP and EEP source
	input  logic                          data_valid_i,
	input  logic [spw_tx_pkg::BYTE_W:0]   data_i,
	output logic                          data_ready_o,
	// Link lines
	output logic                          d_o,
	output logic                          s_o
);

	// Serial bit stream to the line coder
	logic ser_bit;
	logic ser_bit_valid;

	// Held character toward the serializer
	spw_char_if char_if ();

	// ----------------------------------------------------------
	// Stage 1 selection
	// ----------------------------------------------------------
	spw_char_select select_i (
		.pclk_tx      (pclk_tx),
		.enable_tx    (enable_tx),
		.send_null_i  (send_null_i),
		.tc_valid_i   (tc_valid_i),
		.tc_i         (tc_i),
		.fct_valid_i  (fct_valid_i),
		.data_valid_i (data_valid_i),
		.data_i       (data_i),
		.tc_ready_o   (tc_ready_o),
		.fct_ready_o  (fct_ready_o),
		.data_ready_o (data_ready_o),
		.out_if       (char_if.src)
	);

	// Stage 2 serialization with parity
	spw_char_serialize serialize_i (
		.pclk_tx     (pclk_tx),
		.enable_tx   (enable_tx),
		.in_if       (char_if.dst),
		.bit_o       (ser_bit),
		.bit_valid_o (ser_bit_valid)
	);

	// Stage 3 data/strobe lines
	spw_ds_encode encode_i (
		.pclk_tx     (pclk_tx),
		.enable_tx   (enable_tx),
		.bit_i       (ser_bit),
		.bit_valid_i (ser_bit_valid),
		.d_o         (d_o),
		.s_o         (s_o)
	);

endmodule

// ==== rtl/spw_tx_pkg.sv ====
// Character kinds, control codes, character lengths, widths and the character body union
package spw_tx_pkg;

	// ----------------------------------------------------------
	// Widths
	// ----------------------------------------------------------

	// Data byte
	localparam int BYTE_W = 8;
	// Bit counter inside the serializer
	localparam int CNT_W  = 4;
	// Character kind code
	localparam int KIND_W = 3;

	// ----------------------------------------------------------
	// Character kinds
	// ----------------------------------------------------------

	localparam logic [KIND_W-1:0] KIND_NULL = 3'd0;
	localparam logic [KIND_W-1:0] KIND_FCT  = 3'd1;
	localparam logic [KIND_W-1:0] KIND_EOP  = 3'd2;
	localparam logic [KIND_W-1:0] KIND_EEP  = 3'd3;
	localparam logic [KIND_W-1:0] KIND_DATA = 3'd4;
	// ESC followed by a data character with the time byte
	localparam logic [KIND_W-1:0] KIND_TIME = 3'd5;

	// ----------------------------------------------------------
	// Control codes
	// ----------------------------------------------------------

	// Sent lsb first, right after the flag
	localparam logic [1:0] CODE_FCT = 2'b00;
	localparam logic [1:0] CODE_EOP = 2'b01;
	localparam logic [1:0] CODE_EEP = 2'b10;
	localparam logic [1:0] CODE_ESC = 2'b11;

	// Character lengths in bits
	// Parity, flag, two code bits
	localparam logic [CNT_W-1:0] LEN_CTRL = 4'd4;
	// Parity, flag, eight data bits
	localparam logic [CNT_W-1:0] LEN_DATA = 4'd10;
	// ESC then FCT
	localparam logic [CNT_W-1:0] LEN_NULL = 4'd8;
	// ESC then one data character
	localparam logic [CNT_W-1:0] LEN_TIME = 4'd14;

	// Character body
	// Data byte for DATA and TIME kinds
	// Control field for FCT, EOP, EEP and NULL
	typedef union packed {
		logic [BYTE_W-1:0] data;
		struct packed {
			// Unused upper bits
			logic [BYTE_W-3:0] pad;
			logic [1:0]        code;
		} ctrl;
	} char_body_u;

endpackage

// ==== verilog.f ====
+incdir+dv
rtl/spw_tx_pkg.sv
rtl/spw_char_if.sv
rtl/spw_char_select.sv
rtl/spw_char_serialize.sv
rtl/spw_ds_encode.sv
rtl/spw_tx.sv
dv/spw_tx_tb.sv
